/* rtl/cd_xfer_pkg.sv */
package cd_xfer_pkg;

	////////////////////////////////////////////////////////////
	// Host download side
	////////////////////////////////////////////////////////////

	localparam int WORD_W = 16;        // Host download word
	localparam int INDEX_SEL_W = 6;    // Index bits that pick the target

	// Low index bits of a CD data download
	localparam logic [INDEX_SEL_W-1:0] CD_DATA_INDEX = 6'h02;

	////////////////////////////////////////////////////////////
	// Header word layout
	////////////////////////////////////////////////////////////

	// First word of a download is {dm, len[14:0]}
	localparam int HDR_DM_BIT = 15;    // Data mode flag
	localparam int LEN_W = 15;         // Byte length field, bits LEN_W-1..0

	////////////////////////////////////////////////////////////
	// CD core side
	////////////////////////////////////////////////////////////

	localparam int BYTE_W = 8;

	// One buffered data word
	// single_byte marks the tail of an odd length where only the low byte counts
	typedef struct packed {
		logic              single_byte;
		logic [WORD_W-1:0] data;
	} cd_word_t;

endpackage

/* rtl/cd_buf_pkg.sv */
package cd_buf_pkg;

	// Word buffer between header parsing and byte output
	localparam int BUF_ADDR_W = 3;               // Pointer bits
	localparam int BUF_DEPTH = 1 << BUF_ADDR_W;  // Entries

endpackage

/* rtl/cd_word_capture.sv */
module cd_word_capture (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic                           ioctl_download,
	input  logic [7:0]                     ioctl_index,
	input  logic                           ioctl_wr,
	input  logic [cd_xfer_pkg::WORD_W-1:0] ioctl_dout,
	output logic                           push,
	output cd_xfer_pkg::cd_word_t          push_entry,
	output logic                           cd_dm
);

	typedef logic [cd_xfer_pkg::LEN_W-1:0] len_t;

	logic cd_dat_download;
	logic old_download;
	logic dl_start;
	logic head_pos;       // Header already taken
	logic hdr_strobe;
	len_t dat_len;
	len_t dat_cnt;        // Bytes accepted so far
	len_t dat_left;
	logic last_odd;

	////////////////////////////////////////////////////////////
	// Download select and start detect
	////////////////////////////////////////////////////////////

	assign cd_dat_download = ioctl_download &&
		(ioctl_index[cd_xfer_pkg::INDEX_SEL_W-1:0] == cd_xfer_pkg::CD_DATA_INDEX);

	assign dl_start = cd_dat_download && !old_download;

	// A strobe on the start cycle itself is still the header
	assign hdr_strobe = ioctl_wr && cd_dat_download && (dl_start || !head_pos);

	////////////////////////////////////////////////////////////
	// Data words
	////////////////////////////////////////////////////////////

	assign dat_left = dat_len - dat_cnt;
	assign last_odd = (dat_left == len_t'(1));   // Only one byte still owed

	// Words past the stated length are dropped here
	assign push = ioctl_wr && cd_dat_download && head_pos && !dl_start &&
		(dat_cnt < dat_len);

	always_comb begin
		push_entry.data = ioctl_dout;
		push_entry.single_byte = last_odd;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			head_pos <= 1'b0;
			dat_len <= '0;
			dat_cnt <= '0;
			cd_dm <= 1'b0;
		end else begin
			old_download <= cd_dat_download;

			// New download waits for a fresh header
			if (dl_start) begin
				head_pos <= 1'b0;
				dat_cnt <= '0;
			end

			if (hdr_strobe) begin
				cd_dm <= ioctl_dout[cd_xfer_pkg::HDR_DM_BIT];
				dat_len <= ioctl_dout[cd_xfer_pkg::LEN_W-1:0];
				dat_cnt <= '0;
				head_pos <= 1'b1;
			end else if (push) begin
				dat_cnt <= dat_cnt + (last_odd ? len_t'(1) : len_t'(2));
			end
		end
	end

endmodule

/* rtl/cd_word_fifo.sv */
module cd_word_fifo #(
	parameter int depth = cd_buf_pkg::BUF_DEPTH
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  push,
	input  cd_xfer_pkg::cd_word_t push_entry,
	output logic                  full,
	output cd_xfer_pkg::cd_word_t head,
	output logic                  avail,
	input  logic                  pop
);

	typedef logic [(depth > 1 ? $clog2(depth) : 1)-1:0] ptr_t;
	typedef logic [$clog2(depth+1)-1:0] cnt_t;

	cd_xfer_pkg::cd_word_t mem [depth];

	ptr_t wr_ptr;
	ptr_t rd_ptr;
	cnt_t count;      // Entries held

	function automatic ptr_t ptr_next(input ptr_t ptr);
		ptr_next = (ptr == ptr_t'(depth - 1)) ? '0 : ptr + ptr_t'(1);
	endfunction

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (push) begin
			mem[wr_ptr] <= push_entry;
		end
	end

	assign head = mem[rd_ptr];   // Visible the cycle after its push

	////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end

			case ({push, pop})
				2'b10: count <= count + cnt_t'(1);
				2'b01: count <= count - cnt_t'(1);
				default: count <= count;      // Idle or push with pop
			endcase
		end
	end

	assign avail = (count != '0);
	assign full = (count == cnt_t'(depth));  // Drives the host wait level

	// Producer relies on the host seeing full in time
	a_no_push_full: assert property (
		@(posedge clk_sys) disable iff (reset) push |-> !full
	) else $error("cd_word_fifo push while full");

	// Consumer only pops a word it has streamed
	a_no_pop_empty: assert property (
		@(posedge clk_sys) disable iff (reset) pop |-> avail
	) else $error("cd_word_fifo pop while empty");

endmodule

/* rtl/cd_byte_streamer.sv */
module cd_byte_streamer (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  cd_xfer_pkg::cd_word_t          head,
	input  logic                           avail,
	output logic                           pop,
	output logic [cd_xfer_pkg::BYTE_W-1:0] cd_data,
	output logic                           cd_wr
);

	// LOW and HIGH carry the strobe and GAP keeps it low for a cycle
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOW,
		ST_HIGH,
		ST_GAP
	} state_t;

	state_t state;
	logic hi_pending;    // High byte of the head word still to go

	////////////////////////////////////////////////////////////
	// Byte sequencer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= ST_IDLE;
			hi_pending <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (avail) begin
						state <= ST_LOW;
					end
				end
				ST_LOW: begin
					hi_pending <= !head.single_byte;  // Odd tail stops here
					state <= ST_GAP;
				end
				ST_HIGH: begin
					hi_pending <= 1'b0;
					state <= ST_GAP;
				end
				ST_GAP: begin
					state <= hi_pending ? ST_HIGH : ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////

	assign cd_wr = (state == ST_LOW) || (state == ST_HIGH);

	// Low byte first
	assign cd_data = (state == ST_HIGH) ?
		head.data[cd_xfer_pkg::BYTE_W +: cd_xfer_pkg::BYTE_W] :
		head.data[cd_xfer_pkg::BYTE_W-1:0];

	// Word is released in the gap after its last byte
	assign pop = (state == ST_GAP) && !hi_pending;

	// Both bytes come from the same head word
	a_head_stable: assert property (
		@(posedge clk_sys) disable iff (reset) avail && !pop |=> $stable(head)
	) else $error("head changed before its word was popped");

endmodule

/* rtl/cd_data_loader.sv */
module cd_data_loader (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic                           ioctl_download,
	input  logic [7:0]                     ioctl_index,
	input  logic                           ioctl_wr,
	input  logic [cd_xfer_pkg::WORD_W-1:0] ioctl_dout,
	output logic                           ioctl_wait,
	output logic [cd_xfer_pkg::BYTE_W-1:0] cd_data,
	output logic                           cd_wr,
	output logic                           cd_dm
);

	logic                  push;
	cd_xfer_pkg::cd_word_t push_entry;
	logic                  full;
	cd_xfer_pkg::cd_word_t head;
	logic                  avail;
	logic                  pop;

	////////////////////////////////////////////////////////////
	// Header parse and word capture
	////////////////////////////////////////////////////////////

	cd_word_capture u_cd_word_capture (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_dout     (ioctl_dout),
		.push           (push),
		.push_entry     (push_entry),
		.cd_dm          (cd_dm)
	);

	////////////////////////////////////////////////////////////
	// Word buffer
	////////////////////////////////////////////////////////////

	cd_word_fifo #(
		.depth (1 << cd_buf_pkg::BUF_ADDR_W)
	) u_cd_word_fifo (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.push       (push),
		.push_entry (push_entry),
		.full       (full),
		.head       (head),
		.avail      (avail),
		.pop        (pop)
	);

	assign ioctl_wait = full;   // Host holds off while the buffer is full

	////////////////////////////////////////////////////////////
	// Byte output to the CD core
	////////////////////////////////////////////////////////////

	cd_byte_streamer u_cd_byte_streamer (
		.clk_sys (clk_sys),
		.reset   (reset),
		.head    (head),
		.avail   (avail),
		.pop     (pop),
		.cd_data (cd_data),
		.cd_wr   (cd_wr)
	);

	// Host must honor the wait level or words are lost
	a_host_honors_wait: assert property (
		@(posedge clk_sys) disable iff (reset) ioctl_wr |-> !ioctl_wait
	) else $error("ioctl_wr while ioctl_wait is high");

endmodule

/* verification/tb_cd_data_loader.sv */
module tb_cd_data_loader;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int WAIT_LIMIT = 200;     // Host stall limit on ioctl_wait
	localparam int DRAIN_LIMIT = 2000;   // Cycles allowed for the last bytes
	localparam int QUIET_CYCLES = 16;

	localparam logic [7:0] IDX_CD = 8'h02;
	localparam logic [7:0] IDX_CD_HIGH = 8'h42;  // Upper index bits ignored
	localparam logic [7:0] IDX_OTHER = 8'h01;

	logic                           clk_sys;
	logic                           reset;
	logic                           ioctl_download;
	logic [7:0]                     ioctl_index;
	logic                           ioctl_wr;
	logic [cd_xfer_pkg::WORD_W-1:0] ioctl_dout;
	logic                           ioctl_wait;
	logic [cd_xfer_pkg::BYTE_W-1:0] cd_data;
	logic                           cd_wr;
	logic                           cd_dm;

	int seed = 71;
	int check_errors = 0;
	int assert_errors = 0;
	int timeouts = 0;

	// Reference byte stream, read back through exp_rd
	logic [7:0] exp_q [$];
	int         exp_rd = 0;
	int         exp_cnt = 0;
	logic [7:0] exp_head = 8'h00;

	int         wr_count = 0;
	int         wait_hits = 0;
	logic [1:0] dm_seen = 2'b00;

	logic hdr_sent;      // High during the header strobe cycle
	logic dm_exp;
	logic dm_known;
	logic foreign_dl;    // Download aimed at some other target

	cd_data_loader u_cd_data_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wait     (ioctl_wait),
		.cd_data        (cd_data),
		.cd_wr          (cd_wr),
		.cd_dm          (cd_dm)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////
	// Output monitor, runs mid cycle where outputs are settled
	////////////////////////////////////////////////////////////

	always @(negedge clk_sys) begin
		exp_cnt <= exp_q.size() - exp_rd;
		exp_head <= (exp_rd < exp_q.size()) ? exp_q[exp_rd] : 8'h00;
		if (!reset && cd_wr) begin
			wr_count <= wr_count + 1;
			if (exp_rd < exp_q.size()) begin
				exp_rd <= exp_rd + 1;   // Byte of this cycle consumed
			end
		end
		if (ioctl_wait) begin
			wait_hits <= wait_hits + 1;
		end
		if (dm_known && !hdr_sent) begin
			dm_seen[cd_dm] <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	a_reset_quiet: assert property (
		@(posedge clk_sys) $fell(reset) |-> !cd_wr && !ioctl_wait
	) else begin
		assert_errors++;
		$display("FAILED cd_wr/ioctl_wait after reset: got %h/%h expected 0/0",
			$sampled(cd_wr), $sampled(ioctl_wait));
	end

	a_byte_order: assert property (
		@(posedge clk_sys) disable iff (reset) cd_wr && exp_cnt != 0 |-> cd_data == exp_head
	) else begin
		assert_errors++;
		$display("FAILED cd_data: got %h expected %h", $sampled(cd_data), exp_head);
	end

	a_wr_expected: assert property (
		@(posedge clk_sys) disable iff (reset) cd_wr |-> exp_cnt != 0
	) else begin
		assert_errors++;
		$display("Byte %h written to the CD core with no byte left to expect",
			$sampled(cd_data));
	end

	a_wr_pulse: assert property (
		@(posedge clk_sys) disable iff (reset) cd_wr |=> !cd_wr
	) else begin
		assert_errors++;
		$display("FAILED cd_wr: got %h expected %h", $sampled(cd_wr), 1'b0);
	end

	// cd_dm may lag the header strobe by one cycle
	a_dm_follows_header: assert property (
		@(posedge clk_sys) disable iff (reset) dm_known && !hdr_sent |-> cd_dm == dm_exp
	) else begin
		assert_errors++;
		$display("FAILED cd_dm: got %h expected %h", $sampled(cd_dm), dm_exp);
	end

	a_foreign_silent: assert property (
		@(posedge clk_sys) disable iff (reset) foreign_dl |-> !cd_wr
	) else begin
		assert_errors++;
		$display("CD byte written during a download for another target");
	end

	a_host_wait: assert property (
		@(posedge clk_sys) disable iff (reset) ioctl_wr |-> !ioctl_wait
	) else begin
		assert_errors++;
		$display("Host strobed ioctl_wr while ioctl_wait was high");
	end

	////////////////////////////////////////////////////////////
	// Host side stimulus
	////////////////////////////////////////////////////////////

	// One strobe, held off while the buffer is full
	task automatic send_word(input logic [cd_xfer_pkg::WORD_W-1:0] word, input int gap,
			input logic is_header);
		int waited;

		waited = 0;
		repeat (gap) @(posedge clk_sys);
		@(negedge clk_sys);
		while (ioctl_wait && waited < WAIT_LIMIT) begin
			waited++;
			@(negedge clk_sys);
		end
		if (ioctl_wait) begin
			timeouts++;
			$display("Timeout while ioctl_wait stayed high for %0d cycles", WAIT_LIMIT);
		end else begin
			@(posedge clk_sys);
			ioctl_wr <= 1'b1;
			ioctl_dout <= word;
			hdr_sent <= is_header;
			if (is_header) begin
				dm_exp <= word[cd_xfer_pkg::HDR_DM_BIT];
				dm_known <= 1'b1;
			end
			@(posedge clk_sys);
			ioctl_wr <= 1'b0;
			hdr_sent <= 1'b0;
		end
	endtask

	task automatic run_download(input logic [7:0] index, input logic dm, input int len,
			input int extra_words, input logic burst);
		logic [cd_xfer_pkg::WORD_W-1:0] header;
		logic [cd_xfer_pkg::WORD_W-1:0] word;
		logic [31:0]                    rnd;
		logic                           cd_target;
		int n_words;
		int left;
		int gap;
		int exp_bytes;
		int start_count;
		int waited;

		cd_target = (index[cd_xfer_pkg::INDEX_SEL_W-1:0] == cd_xfer_pkg::CD_DATA_INDEX);
		header = '0;
		header[cd_xfer_pkg::HDR_DM_BIT] = dm;
		header[cd_xfer_pkg::LEN_W-1:0] = len[cd_xfer_pkg::LEN_W-1:0];
		n_words = (len + 1) / 2 + extra_words;
		left = len;
		exp_bytes = 0;
		start_count = wr_count;

		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index <= index;
		foreign_dl <= !cd_target;
		send_word(header, 1, cd_target);

		for (int i = 0; i < n_words; i++) begin
			rnd = $random(seed);
			word = rnd[15:0];
			// Low byte first, nothing past the stated length
			if (cd_target && left > 0) begin
				exp_q.push_back(word[7:0]);
				exp_bytes++;
				left--;
				if (left > 0) begin
					exp_q.push_back(word[15:8]);
					exp_bytes++;
					left--;
				end
			end
			gap = burst ? 0 : int'(rnd[18:16]);
			send_word(word, gap, 1'b0);
		end

		@(posedge clk_sys);
		ioctl_download <= 1'b0;

		waited = 0;
		while (exp_cnt != 0 && waited < DRAIN_LIMIT) begin
			waited++;
			@(posedge clk_sys);
		end
		if (exp_cnt != 0) begin
			timeouts++;
			$display("Timeout with %0d expected bytes never seen on cd_data", exp_cnt);
		end

		repeat (QUIET_CYCLES) @(posedge clk_sys);   // Room for stray bytes
		foreign_dl <= 1'b0;

		a_byte_count: assert (wr_count - start_count == exp_bytes) else begin
			check_errors++;
			$display("FAILED cd_wr count: got %h expected %h",
				wr_count - start_count, exp_bytes);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int hits_before;

		reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		ioctl_wr = 1'b0;
		ioctl_dout = '0;
		hdr_sent = 1'b0;
		dm_exp = 1'b0;
		dm_known = 1'b0;
		foreign_dl = 1'b0;

		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (4) @(posedge clk_sys);

		run_download(IDX_CD, 1'b0, 40, 0, 1'b0);       // Even length
		run_download(IDX_CD_HIGH, 1'b1, 23, 3, 1'b0);  // Odd length, words past the end

		// Strobes as fast as the host may go
		hits_before = wait_hits;
		run_download(IDX_CD, 1'b0, 64, 0, 1'b1);
		a_wait_seen: assert (wait_hits > hits_before) else begin
			check_errors++;
			$display("ioctl_wait never rose during the burst download");
		end

		run_download(IDX_OTHER, 1'b1, 10, 0, 1'b0);

		a_both_modes: assert (dm_seen == 2'b11) else begin
			check_errors++;
			$display("FAILED cd_dm values seen: got %h expected %h", dm_seen, 2'b11);
		end

		$display("Done with %0d check errors, %0d assertion errors and %0d timeouts",
			check_errors, assert_errors, timeouts);
		if (check_errors == 0 && assert_errors == 0 && timeouts == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* sim.f */
rtl/cd_xfer_pkg.sv
rtl/cd_buf_pkg.sv
rtl/cd_word_capture.sv
rtl/cd_word_fifo.sv
rtl/cd_byte_streamer.sv
rtl/cd_data_loader.sv
verification/tb_cd_data_loader.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CD data loader testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_cd_data_loader \
	-f sim.f \
	-o tb_cd_data_loader

./obj_dir/tb_cd_data_loader | tee sim.log

if grep -qx "Regression passed" sim.log; then
	exit 0
fi
exit 1
